// ==== sources.f ====
design/rr_trace_pkg.sv
design/rr_csr_pkg.sv
design/rr_stream_if.sv
design/rr_unit_len.sv
design/rr_record_packer.sv
design/rr_replay_unpacker.sv
design/rr_trace_buffer.sv
design/rr_storage_backend.sv
tests/rr_storage_backend_tb.sv

// ==== Bender.yml ====
package:
  name: rr_storage_backend

sources:
  - design/rr_trace_pkg.sv
  - design/rr_csr_pkg.sv
  - design/rr_stream_if.sv
  - design/rr_unit_len.sv
  - design/rr_record_packer.sv
  - design/rr_replay_unpacker.sv
  - design/rr_trace_buffer.sv
  - design/rr_storage_backend.sv
  - target: test
    files:
      - tests/rr_storage_backend_tb.sv

// ==== tests/rr_storage_backend_tb.sv ====
`timescale 1ns/1ns

// Records a table of units and flushes it before replaying under random back-pressure
module rr_storage_backend_tb;

  localparam int NUM_ENTRIES = 24;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  // Roughly 40 cycles per unit covers record and replay with stalls
  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 200;
  // Cycles watched after replay_done
  localparam int QUIET_CYCLES = 16;

  // Header bitmaps per entry
  // Entries 5 and 18 are empty and entry 9 carries a header only
  localparam logic [rr_trace_pkg::LOGB_CHANNEL_CNT-1:0] TBL_LOGB [NUM_ENTRIES] = '{
    3'b111, 3'b001, 3'b010, 3'b100, 3'b011, 3'b000, 3'b110, 3'b101,
    3'b001, 3'b000, 3'b111, 3'b010, 3'b100, 3'b101, 3'b011, 3'b110,
    3'b111, 3'b001, 3'b000, 3'b100, 3'b010, 3'b111, 3'b011, 3'b101
  };
  localparam logic [rr_trace_pkg::LOGE_CHANNEL_CNT-1:0] TBL_LOGE [NUM_ENTRIES] = '{
    2'b00, 2'b01, 2'b10, 2'b11, 2'b00, 2'b00, 2'b01, 2'b10,
    2'b11, 2'b01, 2'b00, 2'b10, 2'b01, 2'b11, 2'b00, 2'b10,
    2'b01, 2'b00, 2'b00, 2'b11, 2'b10, 2'b01, 2'b00, 2'b11
  };

  logic                         clk;
  logic                         reset;
  logic                         record_valid;
  logic                         record_ready;
  rr_trace_pkg::unit_t          record_data;
  rr_trace_pkg::len_t           record_len;
  logic                         replay_valid;
  logic                         replay_ready;
  rr_trace_pkg::unit_t          replay_data;
  rr_trace_pkg::len_t           replay_len;
  rr_csr_pkg::storage_csr_t     csr;
  rr_csr_pkg::storage_counter_t counter;
  logic                         replay_done;

  // Random channel payloads filled at start
  logic [31:0]                  tbl_payload [NUM_ENTRIES][rr_trace_pkg::LOGB_CHANNEL_CNT];
  rr_trace_pkg::unit_t          rec_data [NUM_ENTRIES];
  rr_trace_pkg::len_t           rec_len [NUM_ENTRIES];
  // Expected replay list without the empty units
  rr_trace_pkg::unit_t          exp_data [$];
  rr_trace_pkg::len_t           exp_len [$];
  rr_csr_pkg::storage_counter_t exp_counter;
  int                           cycle_count;

  rr_storage_backend i_dut (
    .clk         (clk),
    .reset       (reset),
    .record_valid(record_valid),
    .record_ready(record_ready),
    .record_data (record_data),
    .record_len  (record_len),
    .replay_valid(replay_valid),
    .replay_ready(replay_ready),
    .replay_data (replay_data),
    .replay_len  (replay_len),
    .csr         (csr),
    .counter     (counter),
    .replay_done (replay_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog on the whole run
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_with_failure($sformatf("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES));
  end

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_unit(input string name,
                            input rr_trace_pkg::unit_t exp_d, input rr_trace_pkg::len_t exp_l,
                            input rr_trace_pkg::unit_t act_d, input rr_trace_pkg::len_t act_l);
    if ((act_d !== exp_d) || (act_l !== exp_l)) begin
      stop_with_failure($sformatf("[ERROR] %s: expected data %h len %0d, actual data %h len %0d",
                                  name, exp_d, exp_l, act_d, act_l));
    end
  endtask

  task automatic check_counter(input string name,
                               input rr_csr_pkg::storage_counter_t exp_c,
                               input rr_csr_pkg::storage_counter_t act_c);
    if (act_c !== exp_c) begin
      stop_with_failure($sformatf(
          "[ERROR] %s: expected words %0d units %0d, actual words %0d units %0d",
          name, exp_c.record_words, exp_c.record_units,
          act_c.record_words, act_c.record_units));
    end
  endtask

  // Layout model with the header at the LSB and the valid channels above it back to back
  task automatic build_unit(input int idx, output rr_trace_pkg::unit_t data,
                            output rr_trace_pkg::len_t len);
    int          pos;
    logic [31:0] payload;
    data = rr_trace_pkg::unit_t'(TBL_LOGB[idx]) |
           (rr_trace_pkg::unit_t'(TBL_LOGE[idx]) << rr_trace_pkg::LOGB_CHANNEL_CNT);
    pos = rr_trace_pkg::HEADER_WIDTH;
    for (int ch = 0; ch < rr_trace_pkg::LOGB_CHANNEL_CNT; ch++) begin
      if (TBL_LOGB[idx][ch]) begin
        payload = tbl_payload[idx][ch] & ((32'd1 << rr_trace_pkg::CHANNEL_WIDTHS[ch]) - 32'd1);
        data = data | (rr_trace_pkg::unit_t'(payload) << pos);
        pos += rr_trace_pkg::CHANNEL_WIDTHS[ch];
      end
    end
    len = rr_trace_pkg::len_t'(pos);
  endtask

  // Starts just after a rising edge and returns after the transfer edge
  task automatic send_unit(input int idx);
    record_valid <= 1'b1;
    record_data  <= rec_data[idx];
    record_len   <= rec_len[idx];
    @(negedge clk);
    if (!record_ready) begin
      stop_with_failure($sformatf("record_ready was low while offering entry %0d", idx));
    end
    @(posedge clk);
  endtask

  initial begin
    int                  sum_bits;
    int                  got;
    logic                done_seen;
    logic                prev_stall;
    rr_trace_pkg::unit_t prev_data;
    rr_trace_pkg::len_t  prev_len;

    void'($urandom(32'h23d8));
    reset        = 1'b1;
    record_valid = 1'b0;
    record_data  = '0;
    record_len   = '0;
    replay_ready = 1'b0;
    csr          = '0;

    // Build the stimulus and the expected replay list
    sum_bits = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      for (int ch = 0; ch < rr_trace_pkg::LOGB_CHANNEL_CNT; ch++) begin
        tbl_payload[i][ch] = $urandom;
      end
      build_unit(i, rec_data[i], rec_len[i]);
      if ((TBL_LOGB[i] != '0) || (TBL_LOGE[i] != '0)) begin
        exp_data.push_back(rec_data[i]);
        exp_len.push_back(rec_len[i]);
        sum_bits += rec_len[i];
      end
    end
    exp_counter.record_words = (sum_bits + rr_trace_pkg::WORD_WIDTH - 1) / rr_trace_pkg::WORD_WIDTH;
    exp_counter.record_units = exp_data.size();

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (!record_ready || replay_valid || replay_done) begin
      stop_with_failure("Stream or done outputs are wrong after reset");
    end
    check_counter("counters after reset", '0, counter);

    // Record phase with one entry per cycle
    @(posedge clk);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      send_unit(i);
    end
    record_valid       <= 1'b0;
    csr.record_finish  <= 1'b1;
    @(posedge clk);
    csr.record_finish  <= 1'b0;
    // Flush cycle and then one idle cycle
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_counter("counters after finish", exp_counter, counter);

    // Replay everything that was written
    @(posedge clk);
    csr.replay_start <= 1'b1;
    csr.replay_words <= exp_counter.record_words;
    @(posedge clk);
    csr.replay_start <= 1'b0;

    got        = 0;
    done_seen  = 1'b0;
    prev_stall = 1'b0;
    prev_data  = '0;
    prev_len   = '0;
    while (!done_seen) begin
      @(negedge clk);
      // A stalled unit must stay put
      if (prev_stall) begin
        if (!replay_valid) begin
          stop_with_failure("replay_valid dropped before the unit was taken");
        end
        check_unit("replay hold", prev_data, prev_len, replay_data, replay_len);
      end
      if (replay_done) begin
        if (got != exp_data.size()) begin
          stop_with_failure($sformatf("replay_done came after only %0d units", got));
        end
        done_seen = 1'b1;
      end
      if (replay_valid) begin
        if (got >= exp_data.size()) begin
          stop_with_failure("Extra unit appeared on the replay stream");
        end
        if (replay_ready) begin
          check_unit($sformatf("replay unit %0d", got), exp_data[got], exp_len[got],
                     replay_data, replay_len);
          got++;
        end
      end
      prev_stall = replay_valid && !replay_ready;
      prev_data  = replay_data;
      prev_len   = replay_len;
      @(posedge clk);
      replay_ready <= (($urandom % 2) == 1);
    end

    // Nothing more after completion
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      if (replay_valid || replay_done) begin
        stop_with_failure("Replay activity continued after replay_done");
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/rr_storage_backend.sv ====
`timescale 1ns/1ns

// Trace storage backend: record packer, buffer and replay unpacker
module rr_storage_backend (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           record_valid,
  output logic                           record_ready,
  input  rr_trace_pkg::unit_t            record_data,
  input  rr_trace_pkg::len_t             record_len,
  output logic                           replay_valid,
  input  logic                           replay_ready,
  output rr_trace_pkg::unit_t            replay_data,
  output rr_trace_pkg::len_t             replay_len,
  input  rr_csr_pkg::storage_csr_t       csr,
  output rr_csr_pkg::storage_counter_t   counter,
  output logic                           replay_done
);

  rr_stream_if record_stream ();
  rr_stream_if replay_stream ();

  logic                                   wr_en;
  logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0] wr_addr;
  rr_trace_pkg::word_t                    wr_data;
  logic                                   rd_en;
  logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0] rd_addr;
  rr_trace_pkg::word_t                    rd_data;

  // Record side ports
  assign record_stream.valid = record_valid;
  assign record_stream.data  = record_data;
  assign record_stream.len   = record_len;
  assign record_ready        = record_stream.ready;

  // Replay side ports
  assign replay_valid        = replay_stream.valid;
  assign replay_data         = replay_stream.data;
  assign replay_len          = replay_stream.len;
  assign replay_stream.ready = replay_ready;

  rr_record_packer i_packer (
    .clk    (clk),
    .reset  (reset),
    .in     (record_stream),
    .finish (csr.record_finish),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .words  (counter.record_words),
    .units  (counter.record_units)
  );

  rr_trace_buffer i_buffer (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  rr_replay_unpacker i_unpacker (
    .clk     (clk),
    .reset   (reset),
    .start   (csr.replay_start),
    .word_cnt(csr.replay_words),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .out     (replay_stream),
    .done    (replay_done)
  );

endmodule

// ==== design/rr_trace_buffer.sv ====
`timescale 1ns/1ns

// On-chip trace storage, one write port and one registered read port
module rr_trace_buffer (
  input  logic                                    clk,
  input  logic                                    wr_en,
  input  logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0] wr_addr,
  input  rr_trace_pkg::word_t                     wr_data,
  input  logic                                    rd_en,
  input  logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0] rd_addr,
  output rr_trace_pkg::word_t                     rd_data
);

  rr_trace_pkg::word_t mem [rr_trace_pkg::BUF_DEPTH];

  // Write from the packer
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== design/rr_replay_unpacker.sv ====
`timescale 1ns/1ns

// Reads trace words and cuts them back into units
module rr_replay_unpacker (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    start,
  input  logic [rr_trace_pkg::BUF_ADDR_WIDTH:0]   word_cnt,
  output logic                                    rd_en,
  output logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0] rd_addr,
  input  rr_trace_pkg::word_t                     rd_data,
  rr_stream_if.p                                  out,
  output logic                                    done
);

  rr_trace_pkg::window_t                  win;
  rr_trace_pkg::fill_t                    fill;
  rr_trace_pkg::window_t                  win_drop;
  rr_trace_pkg::fill_t                    fill_drop;
  rr_trace_pkg::fill_t                    drop;
  rr_trace_pkg::fill_t                    skip_len;
  rr_trace_pkg::len_t                     unit_len;
  logic [rr_trace_pkg::BUF_ADDR_WIDTH:0]  words_left;
  logic                                   rd_pending;
  logic                                   active;
  logic                                   more;
  logic                                   hdr_zero;

  // Length of the unit at the low end of the window
  rr_unit_len i_unit_len (
    .logb_valid(win[rr_trace_pkg::LOGB_CHANNEL_CNT-1:0]),
    .len       (unit_len)
  );

  assign more = (words_left != '0) || rd_pending;

  // One read in flight, only while the window runs short
  assign rd_en = active && !rd_pending && (words_left != '0) &&
                 (fill < rr_trace_pkg::FULL_WIDTH);

  // Zero header is word padding
  assign hdr_zero = active && (fill >= rr_trace_pkg::HEADER_WIDTH) &&
                    (win[rr_trace_pkg::HEADER_WIDTH-1:0] == '0);

  // Rest of the oldest word; a full newer word may sit above it
  assign skip_len = (fill > rr_trace_pkg::WORD_FILL) ?
                    fill - rr_trace_pkg::WORD_FILL : fill;

  // Unit is complete in the window
  assign out.valid = active && (fill >= rr_trace_pkg::HEADER_WIDTH) && !hdr_zero &&
                     (unit_len <= fill);
  assign out.len   = unit_len;
  assign out.data  = win[rr_trace_pkg::FULL_WIDTH-1:0] &
                     ~({rr_trace_pkg::FULL_WIDTH{1'b1}} << unit_len);

  always_comb begin
    drop = '0;
    if (out.valid && out.ready) begin
      drop = rr_trace_pkg::fill_t'(unit_len);
    end else if (hdr_zero) begin
      drop = skip_len;
    end else if (active && !more && !out.valid) begin
      // Short tail with nothing left to complete it
      drop = fill;
    end
    win_drop  = win >> drop;
    fill_drop = fill - drop;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      win        <= '0;
      fill       <= '0;
      words_left <= '0;
      rd_addr    <= '0;
      rd_pending <= 1'b0;
      active     <= 1'b0;
      done       <= 1'b0;
    end else begin
      rd_pending <= rd_en;
      done       <= 1'b0;
      // Returned word goes above the remaining bits
      if (rd_pending) begin
        win  <= win_drop | (rr_trace_pkg::window_t'(rd_data) << fill_drop);
        fill <= fill_drop + rr_trace_pkg::WORD_FILL;
      end else begin
        win  <= win_drop;
        fill <= fill_drop;
      end
      if (start) begin
        active     <= 1'b1;
        words_left <= word_cnt;
        rd_addr    <= '0;
      end else begin
        if (rd_en) begin
          words_left <= words_left - 1'b1;
          rd_addr    <= rd_addr + 1'b1;
        end
        // Window drained and no words left
        if (active && (fill == '0) && !more) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/rr_record_packer.sv ====
`timescale 1ns/1ns

// Appends units into a continuous bit stream and emits 64-bit words
module rr_record_packer (
  input  logic                                       clk,
  input  logic                                       reset,
  rr_stream_if.c                                     in,
  input  logic                                       finish,
  output logic                                       wr_en,
  output logic [rr_trace_pkg::BUF_ADDR_WIDTH-1:0]    wr_addr,
  output rr_trace_pkg::word_t                        wr_data,
  output logic [rr_trace_pkg::BUF_ADDR_WIDTH:0]      words,
  output logic [rr_csr_pkg::UNIT_CNT_WIDTH-1:0]      units
);

  rr_trace_pkg::pack_t acc;
  rr_trace_pkg::fill_t fill;
  rr_trace_pkg::pack_t acc_drained;
  rr_trace_pkg::fill_t fill_drained;
  logic                flushing;
  logic                finished;
  logic                take;

  // Only the flush cycle blocks the stream
  assign in.ready = !flushing;

  // Empty headers and units after finish are swallowed
  assign take = in.valid && in.ready && !finished &&
                (in.data[rr_trace_pkg::HEADER_WIDTH-1:0] != '0);

  // Full word pending, or padded residual while flushing
  assign wr_en   = (fill >= rr_trace_pkg::WORD_FILL) || (flushing && (fill != '0));
  assign wr_data = acc[rr_trace_pkg::WORD_WIDTH-1:0];
  // Write address follows the word count
  assign wr_addr = words[rr_trace_pkg::BUF_ADDR_WIDTH-1:0];

  // Remove the word being written this cycle
  always_comb begin
    acc_drained  = acc;
    fill_drained = fill;
    if (wr_en) begin
      acc_drained = acc >> rr_trace_pkg::WORD_WIDTH;
      if (fill >= rr_trace_pkg::WORD_FILL) begin
        fill_drained = fill - rr_trace_pkg::WORD_FILL;
      end else begin
        // Padded flush empties the accumulator
        fill_drained = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc      <= '0;
      fill     <= '0;
      flushing <= 1'b0;
      finished <= 1'b0;
      words    <= '0;
      units    <= '0;
    end else begin
      // New unit lands right above the residual bits
      if (take) begin
        acc   <= acc_drained | (rr_trace_pkg::pack_t'(in.data) << fill_drained);
        fill  <= fill_drained + rr_trace_pkg::fill_t'(in.len);
        units <= units + 1'b1;
      end else begin
        acc  <= acc_drained;
        fill <= fill_drained;
      end
      if (wr_en) begin
        words <= words + 1'b1;
      end
      // First finish starts the flush and freezes the counts
      if (finish && !finished) begin
        flushing <= 1'b1;
        finished <= 1'b1;
      end else if (flushing && (fill <= rr_trace_pkg::WORD_FILL)) begin
        // Last word goes out this cycle
        flushing <= 1'b0;
      end
    end
  end

endmodule

// ==== design/rr_unit_len.sv ====
`timescale 1ns/1ns

// Unit length from the logb_valid bitmap
module rr_unit_len (
  input  logic [rr_trace_pkg::LOGB_CHANNEL_CNT-1:0] logb_valid,
  output rr_trace_pkg::len_t                        len
);

  always_comb begin
    // Header is always present
    len = rr_trace_pkg::len_t'(rr_trace_pkg::HEADER_WIDTH);
    // One constant addition per valid channel
    for (int i = 0; i < rr_trace_pkg::LOGB_CHANNEL_CNT; i++) begin
      if (logb_valid[i]) begin
        len = len + rr_trace_pkg::len_t'(rr_trace_pkg::CHANNEL_WIDTHS[i]);
      end
    end
  end

endmodule

// ==== design/rr_stream_if.sv ====
`timescale 1ns/1ns

// Logging unit stream with valid/ready handshake
interface rr_stream_if;

  logic valid;
  logic ready;
  // Header and packed channel data, zero above len
  rr_trace_pkg::unit_t data;
  // Unit length in bits
  rr_trace_pkg::len_t len;

  // Producer side
  modport p (output valid, output data, output len, input ready);
  // Consumer side
  modport c (input valid, input data, input len, output ready);

endinterface

// ==== design/rr_csr_pkg.sv ====
package rr_csr_pkg;

  // Width of the accepted unit counter
  localparam int UNIT_CNT_WIDTH = 16;

  // Host control
  typedef struct packed {
    // Flush the partial last word, one cycle
    logic record_finish;
    // Begin replay from word 0, one cycle
    logic replay_start;
    // Words to read back
    logic [rr_trace_pkg::BUF_ADDR_WIDTH:0] replay_words;
  } storage_csr_t;

  // Record statistics
  typedef struct packed {
    logic [rr_trace_pkg::BUF_ADDR_WIDTH:0] record_words;
    logic [UNIT_CNT_WIDTH-1:0] record_units;
  } storage_counter_t;

endpackage

// ==== design/rr_trace_pkg.sv ====
package rr_trace_pkg;

  // Logging channels, fixed order with channel 0 first in the data
  localparam int LOGB_CHANNEL_CNT = 3;
  localparam int LOGE_CHANNEL_CNT = 2;
  localparam int CHANNEL_WIDTHS [LOGB_CHANNEL_CNT] = '{8, 12, 20};

  // Header is logb_valid then loge_valid, from the LSB
  localparam int HEADER_WIDTH = LOGB_CHANNEL_CNT + LOGE_CHANNEL_CNT;

  // Sum of all logb channel widths
  function automatic int sum_channel_widths();
    int total;
    total = 0;
    for (int i = 0; i < LOGB_CHANNEL_CNT; i++) begin
      total += CHANNEL_WIDTHS[i];
    end
    return total;
  endfunction

  localparam int FULL_WIDTH = HEADER_WIDTH + sum_channel_widths();
  localparam int OFFSET_WIDTH = $clog2(FULL_WIDTH + 1);

  // Trace buffer geometry
  localparam int WORD_WIDTH = 64;
  localparam int BUF_DEPTH = 64;
  localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH);

  // Packer accumulator: residual below one word plus one full unit
  localparam int PACK_WIDTH = WORD_WIDTH + FULL_WIDTH - 1;
  // Unpacker bit window, two words
  localparam int WINDOW_WIDTH = 2 * WORD_WIDTH;
  localparam int FILL_WIDTH = $clog2(WINDOW_WIDTH + 1);

  typedef logic [FULL_WIDTH-1:0] unit_t;
  typedef logic [OFFSET_WIDTH-1:0] len_t;
  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [PACK_WIDTH-1:0] pack_t;
  typedef logic [WINDOW_WIDTH-1:0] window_t;
  typedef logic [FILL_WIDTH-1:0] fill_t;

  // One word expressed as a bit count
  localparam fill_t WORD_FILL = fill_t'(WORD_WIDTH);

endpackage
